/* verilog/tri_pkg.sv */
package tri_pkg;

  ////////////////////
  // Attribute words
  ////////////////////

  // One vertex or color word, three packed fields
  localparam int attr_w = 96;
  localparam int field_w = 32;

  // Field positions inside a vertex word, z sits in the low field
  localparam int x_lsb = 64;
  localparam int y_lsb = 32;

  ////////////////////
  // Buffering
  ////////////////////

  localparam int fifo_depth = 8;
  localparam int fifo_aw = 3;

  ////////////////////
  // Setup arithmetic
  ////////////////////

  // Coordinate difference, one bit wider than a field
  localparam int diff_w = field_w + 1;

  // Doubled signed area, product of two differences
  localparam int area_w = 2 * diff_w;

  // Gather FSM, a capture state names the slot whose read data
  // shows up on the FIFO ports in that cycle
  typedef enum logic [1:0] {
    gs_idle,
    gs_cap0,
    gs_cap1,
    gs_cap2
  } gather_state_t;

endpackage

/* verilog/tri_if.sv */
interface tri_if;

  // Level from gather, high while a complete triangle is held
  logic ready;

  // Single-cycle pulse from setup when it takes the triangle
  logic dequeue;

  // Three vertex/color pairs, stable while ready is high
  logic [tri_pkg::attr_w-1:0] vtx0;
  logic [tri_pkg::attr_w-1:0] vtx1;
  logic [tri_pkg::attr_w-1:0] vtx2;
  logic [tri_pkg::attr_w-1:0] col0;
  logic [tri_pkg::attr_w-1:0] col1;
  logic [tri_pkg::attr_w-1:0] col2;

  modport gather (
    output ready,
    input  dequeue,
    output vtx0, vtx1, vtx2,
    output col0, col1, col2
  );

  modport setup (
    input  ready,
    output dequeue,
    input  vtx0, vtx1, vtx2,
    input  col0, col1, col2
  );

endinterface

/* verilog/attr_fifo.sv */
module attr_fifo (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       push,
  input  logic [tri_pkg::attr_w-1:0] wdata,
  output logic                       full,
  input  logic                       pop,
  output logic [tri_pkg::attr_w-1:0] rdata,
  output logic                       empty
);

  logic [tri_pkg::attr_w-1:0] mem [tri_pkg::fifo_depth];

  logic [tri_pkg::fifo_aw-1:0] wr_ptr;
  logic [tri_pkg::fifo_aw-1:0] rd_ptr;
  logic [tri_pkg::fifo_aw:0]   count;

  logic do_push;
  logic do_pop;

  // Overflowing pushes and underflowing pops are dropped
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  assign full  = (count == (tri_pkg::fifo_aw + 1)'(tri_pkg::fifo_depth));
  assign empty = (count == '0);

  ////////////////////
  // Storage
  ////////////////////

  always_ff @(posedge clk)
  begin
    if (do_push)
    begin
      mem[wr_ptr] <= wdata;
    end
    // Read port is registered, word appears the cycle after pop
    if (do_pop)
    begin
      rdata <= mem[rd_ptr];
    end
  end

  ////////////////////
  // Pointers and occupancy
  ////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      // Depth is a power of two so pointers wrap on their own
      if (do_push)
      begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop)
      begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

/* verilog/tri_gather.sv */
module tri_gather (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       vertex_empty,
  input  logic                       color_empty,
  output logic                       pop,
  input  logic [tri_pkg::attr_w-1:0] vertex_rdata,
  input  logic [tri_pkg::attr_w-1:0] color_rdata,
  tri_if.gather                      tri_bus
);

  tri_pkg::gather_state_t state;
  tri_pkg::gather_state_t state_next;

  // Pairs requested so far, 0 to 3
  logic [1:0] req_count;
  logic       ready_q;
  logic       pairs_avail;

  // Held triangle
  logic [tri_pkg::attr_w-1:0] vtx_q [3];
  logic [tri_pkg::attr_w-1:0] col_q [3];

  ////////////////////
  // Pop decision
  ////////////////////

  // Both streams must have a word so the pairs stay aligned
  assign pairs_avail = !vertex_empty && !color_empty;

  // One strobe goes to both FIFOs; stops once three are requested
  assign pop = pairs_avail && (req_count != 2'd3);

  // The slot for the data arriving next cycle follows the request count
  always_comb
  begin
    state_next = tri_pkg::gs_idle;
    if (pop)
    begin
      case (req_count)
        2'd0:    state_next = tri_pkg::gs_cap0;
        2'd1:    state_next = tri_pkg::gs_cap1;
        2'd2:    state_next = tri_pkg::gs_cap2;
        default: state_next = tri_pkg::gs_idle;
      endcase
    end
  end

  ////////////////////
  // Control
  ////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state     <= tri_pkg::gs_idle;
      req_count <= 2'd0;
      ready_q   <= 1'b0;
    end
    else
    begin
      state <= state_next;
      if (tri_bus.dequeue)
      begin
        // Triangle taken, start over on the next cycle
        req_count <= 2'd0;
        ready_q   <= 1'b0;
      end
      else
      begin
        if (pop)
        begin
          req_count <= req_count + 2'd1;
        end
        // Last slot lands this cycle
        if (state == tri_pkg::gs_cap2)
        begin
          ready_q <= 1'b1;
        end
      end
    end
  end

  ////////////////////
  // Slot capture
  ////////////////////

  always_ff @(posedge clk)
  begin
    case (state)
      tri_pkg::gs_cap0:
      begin
        vtx_q[0] <= vertex_rdata;
        col_q[0] <= color_rdata;
      end
      tri_pkg::gs_cap1:
      begin
        vtx_q[1] <= vertex_rdata;
        col_q[1] <= color_rdata;
      end
      tri_pkg::gs_cap2:
      begin
        vtx_q[2] <= vertex_rdata;
        col_q[2] <= color_rdata;
      end
      default:
      begin
        // Idle, hold whatever is there
      end
    endcase
  end

  assign tri_bus.ready = ready_q;

  assign tri_bus.vtx0 = vtx_q[0];
  assign tri_bus.vtx1 = vtx_q[1];
  assign tri_bus.vtx2 = vtx_q[2];
  assign tri_bus.col0 = col_q[0];
  assign tri_bus.col1 = col_q[1];
  assign tri_bus.col2 = col_q[2];

endmodule

/* verilog/tri_setup.sv */
module tri_setup (
  input  logic                               clk,
  input  logic                               rst_n,
  tri_if.setup                               tri_bus,
  output logic                               out_valid,
  output logic signed [tri_pkg::field_w-1:0] bbox_min_x,
  output logic signed [tri_pkg::field_w-1:0] bbox_max_x,
  output logic signed [tri_pkg::field_w-1:0] bbox_min_y,
  output logic signed [tri_pkg::field_w-1:0] bbox_max_y,
  output logic signed [tri_pkg::area_w-1:0]  area2,
  output logic        [tri_pkg::attr_w-1:0]  flat_color
);

  // Latched triangle, z and the other colors are not needed
  logic signed [tri_pkg::field_w-1:0] x0, x1, x2;
  logic signed [tri_pkg::field_w-1:0] y0, y1, y2;
  logic        [tri_pkg::attr_w-1:0]  color_q;
  logic                               held;

  logic signed [tri_pkg::diff_w-1:0] dx1, dy1, dx2, dy2;
  logic signed [tri_pkg::area_w-1:0] cross_a, cross_b;

  function automatic logic signed [tri_pkg::field_w-1:0] min3(
    input logic signed [tri_pkg::field_w-1:0] a,
    input logic signed [tri_pkg::field_w-1:0] b,
    input logic signed [tri_pkg::field_w-1:0] c
  );
    logic signed [tri_pkg::field_w-1:0] m;
    m = (a < b) ? a : b;
    return (c < m) ? c : m;
  endfunction

  function automatic logic signed [tri_pkg::field_w-1:0] max3(
    input logic signed [tri_pkg::field_w-1:0] a,
    input logic signed [tri_pkg::field_w-1:0] b,
    input logic signed [tri_pkg::field_w-1:0] c
  );
    logic signed [tri_pkg::field_w-1:0] m;
    m = (a > b) ? a : b;
    return (c > m) ? c : m;
  endfunction

  ////////////////////
  // Take the triangle
  ////////////////////

  // Always able to accept, so take it the first cycle it is offered
  assign tri_bus.dequeue = tri_bus.ready;

  always_ff @(posedge clk)
  begin
    if (tri_bus.ready)
    begin
      x0      <= tri_bus.vtx0[tri_pkg::x_lsb +: tri_pkg::field_w];
      x1      <= tri_bus.vtx1[tri_pkg::x_lsb +: tri_pkg::field_w];
      x2      <= tri_bus.vtx2[tri_pkg::x_lsb +: tri_pkg::field_w];
      y0      <= tri_bus.vtx0[tri_pkg::y_lsb +: tri_pkg::field_w];
      y1      <= tri_bus.vtx1[tri_pkg::y_lsb +: tri_pkg::field_w];
      y2      <= tri_bus.vtx2[tri_pkg::y_lsb +: tri_pkg::field_w];
      color_q <= tri_bus.col0;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      held <= 1'b0;
    end
    else
    begin
      held <= tri_bus.ready;
    end
  end

  ////////////////////
  // Setup math
  ////////////////////

  // Differences sign-extend into one extra bit
  assign dx1 = x1 - x0;
  assign dy1 = y1 - y0;
  assign dx2 = x2 - x0;
  assign dy2 = y2 - y0;

  assign cross_a = dx1 * dy2;
  assign cross_b = dx2 * dy1;
  assign area2   = cross_a - cross_b;

  assign bbox_min_x = min3(x0, x1, x2);
  assign bbox_max_x = max3(x0, x1, x2);
  assign bbox_min_y = min3(y0, y1, y2);
  assign bbox_max_y = max3(y0, y1, y2);
  assign flat_color = color_q;

  // Degenerate triangles are dropped here
  assign out_valid = held && (area2 != '0);

endmodule

/* verilog/tri_assembly_top.sv */
module tri_assembly_top (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               vertex_push,
  input  logic                               color_push,
  input  logic        [tri_pkg::attr_w-1:0]  vertex_data,
  input  logic        [tri_pkg::attr_w-1:0]  color_data,
  output logic                               vertex_full,
  output logic                               color_full,
  output logic                               out_valid,
  output logic signed [tri_pkg::field_w-1:0] bbox_min_x,
  output logic signed [tri_pkg::field_w-1:0] bbox_max_x,
  output logic signed [tri_pkg::field_w-1:0] bbox_min_y,
  output logic signed [tri_pkg::field_w-1:0] bbox_max_y,
  output logic signed [tri_pkg::area_w-1:0]  area2,
  output logic        [tri_pkg::attr_w-1:0]  flat_color
);

  logic                       vertex_empty;
  logic                       color_empty;
  logic [tri_pkg::attr_w-1:0] vertex_rdata;
  logic [tri_pkg::attr_w-1:0] color_rdata;

  // Shared read strobe keeps both streams in step
  logic                       pop;

  tri_if tri_bus ();

  ////////////////////
  // Input buffers
  ////////////////////

  attr_fifo vertex_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .push  (vertex_push),
    .wdata (vertex_data),
    .full  (vertex_full),
    .pop   (pop),
    .rdata (vertex_rdata),
    .empty (vertex_empty)
  );

  attr_fifo color_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .push  (color_push),
    .wdata (color_data),
    .full  (color_full),
    .pop   (pop),
    .rdata (color_rdata),
    .empty (color_empty)
  );

  ////////////////////
  // Assembly and setup
  ////////////////////

  tri_gather tri_gather_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .vertex_empty (vertex_empty),
    .color_empty  (color_empty),
    .pop          (pop),
    .vertex_rdata (vertex_rdata),
    .color_rdata  (color_rdata),
    .tri_bus      (tri_bus.gather)
  );

  tri_setup tri_setup_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .tri_bus    (tri_bus.setup),
    .out_valid  (out_valid),
    .bbox_min_x (bbox_min_x),
    .bbox_max_x (bbox_max_x),
    .bbox_min_y (bbox_min_y),
    .bbox_max_y (bbox_max_y),
    .area2      (area2),
    .flat_color (flat_color)
  );

endmodule

/* tests/tri_checker.sv */
module tri_checker (
  input logic                               clk,
  input logic                               rst_n,
  input logic                               out_valid,
  input logic signed [tri_pkg::field_w-1:0] bbox_min_x,
  input logic signed [tri_pkg::field_w-1:0] bbox_max_x,
  input logic signed [tri_pkg::field_w-1:0] bbox_min_y,
  input logic signed [tri_pkg::field_w-1:0] bbox_max_y,
  input logic signed [tri_pkg::area_w-1:0]  area2,
  input logic        [tri_pkg::attr_w-1:0]  flat_color,
  input logic                               vertex_full,
  input logic                               color_full
);

  typedef struct packed {
    logic [tri_pkg::field_w-1:0] min_x;
    logic [tri_pkg::field_w-1:0] max_x;
    logic [tri_pkg::field_w-1:0] min_y;
    logic [tri_pkg::field_w-1:0] max_y;
    logic [tri_pkg::area_w-1:0]  area;
    logic [tri_pkg::attr_w-1:0]  color;
  } result_t;

  result_t expected_q [$];
  result_t head;
  int      pending = 0;
  int      value_errors = 0;
  int      other_errors = 0;
  bit      full_wanted = 1'b0;

  task automatic add_expected(input logic [31:0] min_x, input logic [31:0] max_x,
                              input logic [31:0] min_y, input logic [31:0] max_y,
                              input logic [65:0] area, input logic [95:0] color);
    expected_q.push_back('{min_x, max_x, min_y, max_y, area, color});
    pending++;
  endtask

  // Vertex FIFO overfilled while the color FIFO is still empty
  task automatic expect_full_levels();
    full_wanted = 1'b1;
  endtask

  task automatic note_error(input string msg);
    $display("%0t: %s", $time, msg);
    other_errors++;
  endtask

  task automatic compare_value(input string name, input logic [95:0] exp, input logic [95:0] act);
    if (exp !== act)
    begin
      $display("FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
      value_errors++;
    end
  endtask

  task automatic report(output int total);
    if (expected_q.size() != 0)
      note_error($sformatf("%0d expected results never produced", expected_q.size()));
    total = value_errors + other_errors;
    $display("Value errors: %0d, other errors: %0d", value_errors, other_errors);
  endtask

  ////////////////////
  // Output watch
  ////////////////////

  always @(posedge clk)
  begin
    if (rst_n && full_wanted)
    begin
      compare_value("vertex_full", 96'd1, {95'd0, vertex_full});
      compare_value("color_full", 96'd0, {95'd0, color_full});
      full_wanted = 1'b0;
    end
    if (rst_n && out_valid)
    begin
      if (expected_q.size() == 0)
        note_error("unexpected result with no expected case left");
      else
      begin
        head = expected_q.pop_front();
        pending--;
        compare_value("bbox_min_x", {64'd0, head.min_x}, {64'd0, bbox_min_x});
        compare_value("bbox_max_x", {64'd0, head.max_x}, {64'd0, bbox_max_x});
        compare_value("bbox_min_y", {64'd0, head.min_y}, {64'd0, bbox_min_y});
        compare_value("bbox_max_y", {64'd0, head.max_y}, {64'd0, bbox_max_y});
        compare_value("area2", {30'd0, head.area}, {30'd0, area2});
        compare_value("flat_color", head.color, flat_color);
      end
    end
  end

endmodule

/* tests/tri_assembly_tb.sv */
module tri_assembly_tb;

  logic                               clk;
  logic                               rst_n;
  logic                               vertex_push;
  logic                               color_push;
  logic        [tri_pkg::attr_w-1:0]  vertex_data;
  logic        [tri_pkg::attr_w-1:0]  color_data;
  logic                               vertex_full;
  logic                               color_full;
  logic                               out_valid;
  logic signed [tri_pkg::field_w-1:0] bbox_min_x;
  logic signed [tri_pkg::field_w-1:0] bbox_max_x;
  logic signed [tri_pkg::field_w-1:0] bbox_min_y;
  logic signed [tri_pkg::field_w-1:0] bbox_max_y;
  logic signed [tri_pkg::area_w-1:0]  area2;
  logic        [tri_pkg::attr_w-1:0]  flat_color;

  // Field a holds the vertex word or the wait count
  byte                        op_kind [$];
  logic [tri_pkg::attr_w-1:0] op_a [$];
  logic [tri_pkg::attr_w-1:0] op_b [$];
  int                         stim_cycles = 0;
  int                         limit_cycles = 0;
  int                         errors = 0;
  bit                         loaded;

  tri_assembly_top tri_assembly_top_inst (.*);

  tri_checker tri_checker_inst (.*);

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic add_op(input byte kind, input logic [95:0] a, input logic [95:0] b);
    op_kind.push_back(kind);
    op_a.push_back(a);
    op_b.push_back(b);
    stim_cycles += (kind == "w") ? int'(a[31:0]) : ((kind == "f") ? 0 : 1);
  endtask

  task automatic read_cases(output bit ok);
    int                         fd;
    int                         n;
    string                      line;
    logic [31:0]                p0, p1, p2, p3, p4, p5, p6, p7, p8;
    logic [tri_pkg::area_w-1:0] area;
    ok = 1'b0;
    fd = $fopen("tests/tri_cases.txt", "r");
    if (fd != 0)
    begin
      ok = 1'b1;
      while ($fgets(line, fd) != 0)
      begin
        case (line.getc(0))
          "v":
          begin
            n = $sscanf(line, "v %h %h %h", p0, p1, p2);
            if (n != 3) ok = 1'b0;
            add_op("v", {p0, p1, p2}, '0);
          end
          "c":
          begin
            n = $sscanf(line, "c %h %h %h", p0, p1, p2);
            if (n != 3) ok = 1'b0;
            add_op("c", '0, {p0, p1, p2});
          end
          // Whole triangle as three pairs with the later colors inverted
          "t":
          begin
            n = $sscanf(line, "t %h %h %h %h %h %h %h %h %h",
                        p0, p1, p2, p3, p4, p5, p6, p7, p8);
            if (n != 9) ok = 1'b0;
            add_op("p", {p0, p1, 32'd0}, {p6, p7, p8});
            add_op("p", {p2, p3, 32'd1}, ~{p6, p7, p8});
            add_op("p", {p4, p5, 32'd2}, ~{p6, p7, p8});
          end
          "w":
          begin
            n = $sscanf(line, "w %d", p0);
            if (n != 1) ok = 1'b0;
            add_op("w", {64'd0, p0}, '0);
          end
          "f": add_op("f", '0, '0);
          "e":
          begin
            n = $sscanf(line, "e %h %h %h %h %h %h %h %h", p0, p1, p2, p3, area, p4, p5, p6);
            if (n != 8) ok = 1'b0;
            tri_checker_inst.add_expected(p0, p1, p2, p3, area, {p4, p5, p6});
          end
          default:
          begin
            // Comment or blank line
          end
        endcase
      end
      $fclose(fd);
    end
  endtask

  // Inputs change 2 units after the edge and are sampled on the next one
  task automatic push_words(input logic do_vertex, input logic do_color,
                            input logic [95:0] vword, input logic [95:0] cword);
    vertex_push = do_vertex;
    color_push  = do_color;
    vertex_data = vword;
    color_data  = cword;
    @(posedge clk);
    #2;
    vertex_push = 1'b0;
    color_push  = 1'b0;
  endtask

  task automatic run_ops();
    for (int k = 0; k < op_kind.size(); k++)
    begin
      case (op_kind[k])
        "v": push_words(1'b1, 1'b0, op_a[k], '0);
        "c": push_words(1'b0, 1'b1, '0, op_b[k]);
        "p":
        begin
          // Pair pushes hold back while either FIFO is full
          while (vertex_full || color_full)
          begin
            @(posedge clk);
            #2;
          end
          push_words(1'b1, 1'b1, op_a[k], op_b[k]);
        end
        "w":
        begin
          repeat (op_a[k][31:0])
          begin
            @(posedge clk);
            #2;
          end
        end
        default: tri_checker_inst.expect_full_levels();
      endcase
    end
  endtask

  initial
  begin
    rst_n       = 1'b0;
    vertex_push = 1'b0;
    color_push  = 1'b0;
    vertex_data = '0;
    color_data  = '0;
    read_cases(loaded);
    if (!loaded)
    begin
      $display("Could not read or parse tests/tri_cases.txt");
      $display("Errors found");
      $finish;
    end
    else
    begin
      limit_cycles = stim_cycles * 8 + 200;
      repeat (10) @(posedge clk);
      #2;
      rst_n = 1'b1;
      run_ops();
      while (tri_checker_inst.pending != 0) @(posedge clk);
      // Room for any stray extra result
      repeat (20) @(posedge clk);
      tri_checker_inst.report(errors);
      if (errors == 0)
        $display("No errors");
      else
        $display("Errors found");
      $finish;
    end
  end

  ////////////////////
  // Watchdog
  ////////////////////

  initial
  begin
    wait (limit_cycles != 0);
    repeat (limit_cycles + 10) @(posedge clk);
    tri_checker_inst.note_error("timeout, the cycle limit ran out before all results came out");
    tri_checker_inst.report(errors);
    $display("Errors found");
    $finish;
  end

endmodule

/* tests/tri_cases.txt */
# v x y z | c r g b | t x0 y0 x1 y1 x2 y2 r g b (three pairs) | w cycles | f (vertex_full high)
# e min_x max_x min_y max_y area2 r g b, all numbers hex except the w count
t 0 0 4 0 0 3 11 22 33
e 0 4 0 3 c 11 22 33
t 1 1 2 2 3 3 e1 e2 e3
t 5 5 5 5 5 5 e4 e5 e6
t a a 14 a a 1e 44 55 66
e a 14 a 1e c8 44 55 66
t a a a 1e 14 a 77 88 99
e a 14 a 1e 3ffffffffffffff38 77 88 99
t 80000000 80000000 7fffffff 80000000 80000000 7fffffff aa bb cc
e 80000000 7fffffff 80000000 7fffffff fffffffe00000001 aa bb cc
t 80000000 80000000 80000000 7fffffff 7fffffff 80000000 dd ee ff
e 80000000 7fffffff 80000000 7fffffff 300000001ffffffff dd ee ff
t 1 2 7 2 4 9 1 2 3
e 1 7 2 9 2a 1 2 3
t fffffffb fffffffb 5 fffffffb 0 5 4 5 6
e fffffffb 5 fffffffb 5 64 4 5 6
t 64 0 0 32 0 0 7 8 9
e 0 64 0 32 1388 7 8 9
w 40
v 0 0 0
v 8 0 0
v 0 8 0
v 2 2 0
v 2 6 0
v 6 2 0
v 1 1 0
v 3 1 0
v 9 9 0
f
c 100 200 300
c 101 201 301
w 3
c 102 202 302
w 5
c 103 203 303
c 104 204 304
w 3
c 105 205 305
w 4
c 106 206 306
c 107 207 307
w 2
c 108 208 308
v 1 5 0
e 0 8 0 8 40 100 200 300
e 2 6 2 6 3fffffffffffffff0 103 203 303
e 1 3 1 5 8 106 206 306

/* verilog.f */
verilog/tri_pkg.sv
verilog/tri_if.sv
verilog/attr_fifo.sv
verilog/tri_gather.sv
verilog/tri_setup.sv
verilog/tri_assembly_top.sv
tests/tri_checker.sv
tests/tri_assembly_tb.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --timing -Wno-fatal
TOP       = tri_assembly_tb
FILELIST  = verilog.f
OBJ_DIR   = obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "No errors"

clean:
	rm -rf $(OBJ_DIR)
